/* flist.f */
+incdir+include
hw/fm_pkg.sv
hw/fm_ch_wr_if.sv
hw/fm_mmr.sv
hw/fm_ch_regs.sv
hw/fm_ch_scan.sv
hw/fm_timers.sv
hw/fm_regif_top.sv
verification/fm_regif_sva.sv
verification/fm_regif_tb.sv

/* hw/fm_ch_regs.sv */
// fm channel parameter bank

`timescale 1ns/10ps

module fm_ch_regs #(
	parameter int CH_IDX = 0
) (
	input  logic                clk,
	input  logic                rst,
	fm_ch_wr_if.bank            wr,
	output fm_pkg::fm_ch_param_t params
);
	import fm_pkg::*;

	logic       hit;
	logic [2:0] blk_pend;  // waits for the low fnum byte
	logic [2:0] fnum_pend;

	assign hit = wr.wr_stb && (wr.wr_ch == 2'(CH_IDX));

	always_ff @(posedge clk) begin
		if (rst) begin
			params    <= '0;
			blk_pend  <= 3'd0;
			fnum_pend <= 3'd0;
		end else if (hit) begin
			case (wr.wr_field)
				FLD_BLK_HI: begin
					blk_pend  <= wr.wr_data[5:3];
					fnum_pend <= wr.wr_data[2:0];
				end
				FLD_FNUM_LO: begin
					// whole frequency changes at once
					params.fnum  <= {fnum_pend, wr.wr_data};
					params.block <= blk_pend;
				end
				FLD_FB_ALG: begin
					params.fb  <= wr.wr_data[5:3];
					params.alg <= wr.wr_data[2:0];
				end
				FLD_PAN_MOD: begin
					params.rl  <= wr.wr_data[7:6];
					params.ams <= wr.wr_data[5:4];
					params.pms <= wr.wr_data[2:0];
				end
				FLD_KEYON: params.keyon <= wr.wr_data[7:4]; // operator mask
				default: ;
			endcase
		end
	end

endmodule

/* hw/fm_ch_scan.sv */
// fm channel slot scanner

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_ch_scan (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clk_en,
	input  fm_pkg::fm_ch_param_t ch_params [`FM_NUM_CH],
	output logic [1:0]           slot_ch,
	output logic [10:0]          fnum,
	output logic [2:0]           block,
	output logic [2:0]           fb,
	output logic [2:0]           alg,
	output logic [1:0]           rl,
	output logic [1:0]           ams,
	output logic [2:0]           pms,
	output logic [3:0]           keyon
);
	import fm_pkg::*;

	fm_ch_param_t cur;
	logic         load; // one clock after the slot moves

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_ch <= 2'd0;
			load    <= 1'b0;
			cur     <= '0;
		end else begin
			load <= clk_en;
			if (clk_en) begin
				if (slot_ch == 2'(`FM_NUM_CH - 1))
					slot_ch <= 2'd0;
				else
					slot_ch <= slot_ch + 2'd1;
			end
			if (load)
				cur <= ch_params[slot_ch];
		end
	end

	assign fnum  = cur.fnum;
	assign block = cur.block;
	assign fb    = cur.fb;
	assign alg   = cur.alg;
	assign rl    = cur.rl;
	assign ams   = cur.ams;
	assign pms   = cur.pms;
	assign keyon = cur.keyon;

endmodule

/* hw/fm_ch_wr_if.sv */
// channel register write bus

`timescale 1ns/10ps

interface fm_ch_wr_if;
	import fm_pkg::*;

	logic        wr_stb;   // one clock per write
	logic [1:0]  wr_ch;
	fm_field_e   wr_field;
	logic [7:0]  wr_data;

	modport dec (
		output wr_stb, wr_ch, wr_field, wr_data
	);

	modport bank (
		input wr_stb, wr_ch, wr_field, wr_data
	);

endinterface

/* hw/fm_mmr.sv */
// fm register decoder

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_mmr (
	input  logic       clk,
	input  logic       rst,
	input  logic       cen,
	input  logic [7:0] din,
	input  logic       write,
	input  logic       addr,
	output logic       clk_en,
	output logic       busy,
	output logic       lfo_en,
	output logic [2:0] lfo_freq,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic       load_a,
	output logic       load_b,
	output logic       flag_en_a,
	output logic       flag_en_b,
	output logic       clr_a,
	output logic       clr_b,
	fm_ch_wr_if.dec    wr
);
	import fm_pkg::*;

	localparam int BUSY_W = $clog2(`FM_BUSY_CYCLES);

	logic              old_write;
	logic              wr_edge;
	logic              addr_edge;
	logic              data_edge;
	logic [7:0]        sel_reg;
	logic [2:0]        cen_cnt;
	logic [2:0]        cen_lim;
	logic [BUSY_W-1:0] busy_cnt;
	logic              ch_hit;
	logic [1:0]        ch_sel;
	fm_field_e         ch_fld;

	assign wr_edge   = write & ~old_write;
	assign addr_edge = wr_edge & ~addr;
	assign data_edge = wr_edge & addr;

	// clock enable divider
	assign clk_en = cen && (cen_cnt == cen_lim);

	always_ff @(posedge clk) begin
		if (rst) begin
			cen_cnt <= 3'd0;
		end else if (cen) begin
			if (cen_cnt >= cen_lim) // limit may drop below count
				cen_cnt <= 3'd0;
			else
				cen_cnt <= cen_cnt + 3'd1;
		end
	end

	// address latch and global registers
	always_ff @(posedge clk) begin
		if (rst) begin
			old_write <= 1'b0;
			sel_reg   <= 8'h00;
			cen_lim   <= 3'd5;
			lfo_en    <= 1'b0;
			lfo_freq  <= 3'd0;
			value_a   <= 10'd0;
			value_b   <= 8'd0;
			{clr_b, clr_a, flag_en_b, flag_en_a, load_b, load_a} <= 6'd0;
		end else begin
			old_write <= write;
			clr_a     <= 1'b0; // clear bits are single cycle
			clr_b     <= 1'b0;
			if (addr_edge)
				sel_reg <= din;
			if (data_edge) begin
				case (sel_reg)
					REG_LFO:   {lfo_en, lfo_freq} <= din[3:0];
					REG_CLKA1: value_a[9:2] <= din;
					REG_CLKA2: value_a[1:0] <= din[1:0];
					REG_CLKB:  value_b <= din;
					REG_TIMER: begin
						{clr_b, clr_a, flag_en_b, flag_en_a, load_b, load_a} <= din[5:0];
					end
					REG_DIV6:  cen_lim <= 3'd5;
					REG_DIV3:  cen_lim <= 3'd2;
					REG_DIV2:  cen_lim <= 3'd1;
					default:   ; // channel regs handled below
				endcase
			end
		end
	end

	// channel address decode
	always_comb begin
		ch_hit = 1'b0;
		ch_sel = sel_reg[1:0];
		ch_fld = FLD_FNUM_LO;
		if (sel_reg == REG_KON) begin
			ch_hit = 1'b1;
			ch_sel = din[1:0]; // key-on names its channel in the data
			ch_fld = FLD_KEYON;
		end else begin
			case (sel_reg[7:2])
				6'h28: begin
					ch_hit = 1'b1;
					ch_fld = FLD_FNUM_LO;
				end
				6'h29: begin
					ch_hit = 1'b1;
					ch_fld = FLD_BLK_HI;
				end
				6'h2C: begin
					ch_hit = 1'b1;
					ch_fld = FLD_FB_ALG;
				end
				6'h2D: begin
					ch_hit = 1'b1;
					ch_fld = FLD_PAN_MOD;
				end
				default: ch_hit = 1'b0;
			endcase
		end
		// slot 3 and any missing bank are dropped
		if (ch_sel >= 2'(`FM_NUM_CH))
			ch_hit = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			wr.wr_stb <= 1'b0;
		else
			wr.wr_stb <= data_edge & ch_hit;
	end

	always_ff @(posedge clk) begin
		if (data_edge) begin
			wr.wr_ch    <= ch_sel;
			wr.wr_field <= ch_fld;
			wr.wr_data  <= din;
		end
	end

	// advisory busy, restarted by every data write
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (data_edge) begin
			busy     <= 1'b1;
			busy_cnt <= '0;
		end else if (busy) begin
			if (busy_cnt == BUSY_W'(`FM_BUSY_CYCLES - 1))
				busy <= 1'b0;
			busy_cnt <= busy_cnt + 1'b1;
		end
	end

endmodule

/* hw/fm_pkg.sv */
// fm register interface types

package fm_pkg;

	// global register map, first bank only
	typedef enum logic [7:0] {
		REG_LFO   = 8'h22,
		REG_CLKA1 = 8'h24, // timer A value bits 9..2
		REG_CLKA2 = 8'h25, // timer A value bits 1..0
		REG_CLKB  = 8'h26,
		REG_TIMER = 8'h27,
		REG_KON   = 8'h28,
		REG_DIV6  = 8'h2D,
		REG_DIV3  = 8'h2E,
		REG_DIV2  = 8'h2F
	} fm_reg_e;

	// which channel field a decoded write targets
	typedef enum logic [2:0] {
		FLD_FNUM_LO, // A0..A2
		FLD_BLK_HI,  // A4..A6, goes to the pending latch
		FLD_FB_ALG,  // B0..B2
		FLD_PAN_MOD, // B4..B6
		FLD_KEYON    // from reg 28
	} fm_field_e;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
		logic [1:0]  ams;
		logic [2:0]  pms;
		logic [3:0]  keyon; // one bit per operator
	} fm_ch_param_t;

endpackage

/* hw/fm_regif_top.sv */
// fm register interface top

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_regif_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        cen,
	input  logic [7:0]  din,
	input  logic        write,
	input  logic        addr,
	output logic        busy,
	output logic        clk_en,
	output logic        irq_n,
	output logic        flag_a,
	output logic        flag_b,
	output logic        lfo_en,
	output logic [2:0]  lfo_freq,
	output logic [1:0]  slot_ch,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output logic [2:0]  alg,
	output logic [1:0]  rl,
	output logic [1:0]  ams,
	output logic [2:0]  pms,
	output logic [3:0]  keyon
);
	import fm_pkg::*;

	logic [9:0]   value_a;
	logic [7:0]   value_b;
	logic         load_a;
	logic         load_b;
	logic         flag_en_a;
	logic         flag_en_b;
	logic         clr_a;
	logic         clr_b;
	fm_ch_param_t ch_params [`FM_NUM_CH];

	fm_ch_wr_if ch_wr ();

	fm_mmr fm_mmr_i (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.din       (din),
		.write     (write),
		.addr      (addr),
		.clk_en    (clk_en),
		.busy      (busy),
		.lfo_en    (lfo_en),
		.lfo_freq  (lfo_freq),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.flag_en_a (flag_en_a),
		.flag_en_b (flag_en_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.wr        (ch_wr.dec)
	);

	// one bank per channel, all on the same write bus
	for (genvar g = 0; g < `FM_NUM_CH; g++) begin : g_ch
		fm_ch_regs #(
			.CH_IDX (g)
		) fm_ch_regs_i (
			.clk    (clk),
			.rst    (rst),
			.wr     (ch_wr.bank),
			.params (ch_params[g])
		);
	end

	fm_ch_scan fm_ch_scan_i (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.ch_params (ch_params),
		.slot_ch   (slot_ch),
		.fnum      (fnum),
		.block     (block),
		.fb        (fb),
		.alg       (alg),
		.rl        (rl),
		.ams       (ams),
		.pms       (pms),
		.keyon     (keyon)
	);

	fm_timers fm_timers_i (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.flag_en_a (flag_en_a),
		.flag_en_b (flag_en_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq_n     (irq_n)
	);

endmodule

/* hw/fm_timers.sv */
// fm timers A and B

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_timers (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic [9:0] value_a,
	input  logic [7:0] value_b,
	input  logic       load_a,
	input  logic       load_b,
	input  logic       flag_en_a,
	input  logic       flag_en_b,
	input  logic       clr_a,
	input  logic       clr_b,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq_n
);
	localparam int PRE_W = $clog2(`FM_TB_PRESCALE);

	logic [9:0]       cnt_a;
	logic [7:0]       cnt_b;
	logic [PRE_W-1:0] pre_b;
	logic             tick_b;
	logic             ovf_a;
	logic             ovf_b;

	assign tick_b = clk_en && (pre_b == PRE_W'(`FM_TB_PRESCALE - 1));
	assign ovf_a  = load_a && clk_en && (cnt_a == 10'h3FF);
	assign ovf_b  = load_b && tick_b && (cnt_b == 8'hFF);

	// timer A, one count per clk_en
	always_ff @(posedge clk) begin
		if (rst)
			cnt_a <= 10'd0;
		else if (!load_a)
			cnt_a <= value_a; // parked on the reload value
		else if (clk_en)
			cnt_a <= ovf_a ? value_a : cnt_a + 10'd1;
	end

	// timer B behind its prescaler
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_b <= 8'd0;
			pre_b <= '0;
		end else if (!load_b) begin
			cnt_b <= value_b;
			pre_b <= '0;
		end else if (clk_en) begin
			pre_b <= tick_b ? '0 : pre_b + 1'b1;
			if (tick_b)
				cnt_b <= ovf_b ? value_b : cnt_b + 8'd1;
		end
	end

	// sticky flags, overflow wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (ovf_a && flag_en_a)
				flag_a <= 1'b1;
			else if (clr_a)
				flag_a <= 1'b0;
			if (ovf_b && flag_en_b)
				flag_b <= 1'b1;
			else if (clr_b)
				flag_b <= 1'b0;
		end
	end

	assign irq_n = ~(flag_a | flag_b);

endmodule

/* include/fm_params.svh */
// fm register interface parameters

`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

// number of channel banks, 2 also works
`define FM_NUM_CH 3

// clocks that busy stays high after a data write
`define FM_BUSY_CYCLES 32

// clk_en ticks per timer B count
`define FM_TB_PRESCALE 16

`endif

/* verification/fm_regif_sva.sv */
// register interface timing checks

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_regif_sva (
	input logic       clk,
	input logic       rst,
	input logic       write,
	input logic       addr,
	input logic       busy,
	input logic       clk_en,
	input logic [1:0] slot_ch,
	input logic       flag_a,
	input logic       flag_b,
	input logic       irq_n
);
	int   fail_cnt = 0;
	logic old_write;
	logic data_wr;

	always_ff @(posedge clk) begin
		if (rst)
			old_write <= 1'b0;
		else
			old_write <= write;
	end

	assign data_wr = write && !old_write && addr; // data write edge

	a_busy_on: assert property (@(posedge clk) disable iff (rst)
		data_wr |=> busy [*`FM_BUSY_CYCLES])
		else begin
			$error("busy dropped before the full count");
			fail_cnt++;
		end

	// without a restart busy ends right on time
	a_busy_off: assert property (@(posedge clk) disable iff (rst)
		data_wr ##1 (!data_wr) [*`FM_BUSY_CYCLES] |=> !busy)
		else begin
			$error("busy held past the full count");
			fail_cnt++;
		end

	a_slot_step: assert property (@(posedge clk) disable iff (rst)
		clk_en |=> slot_ch == (($past(slot_ch) == 2'(`FM_NUM_CH - 1)) ? 2'd0
			: $past(slot_ch) + 2'd1))
		else begin
			$error("slot_ch did not step on clk_en");
			fail_cnt++;
		end

	a_slot_hold: assert property (@(posedge clk) disable iff (rst)
		!clk_en |=> $stable(slot_ch))
		else begin
			$error("slot_ch moved without clk_en");
			fail_cnt++;
		end

	a_irq: assert property (@(posedge clk) disable iff (rst)
		irq_n == !(flag_a || flag_b))
		else begin
			$error("irq_n does not follow the flags");
			fail_cnt++;
		end

endmodule

bind fm_regif_top fm_regif_sva fm_regif_sva_i (.*);

/* verification/fm_regif_tb.sv */
// fm register interface testbench

`timescale 1ns/10ps

`include "fm_params.svh"

module fm_regif_tb;
	import fm_pkg::*;

	localparam int VAL_A = 1020;
	localparam int VAL_B = 254;

	logic        clk;
	logic        rst;
	logic        cen;
	logic [7:0]  din;
	logic        write;
	logic        addr;
	logic        busy;
	logic        clk_en;
	logic        irq_n;
	logic        flag_a;
	logic        flag_b;
	logic        lfo_en;
	logic [2:0]  lfo_freq;
	logic [1:0]  slot_ch;
	logic [10:0] fnum;
	logic [2:0]  block;
	logic [2:0]  fb;
	logic [2:0]  alg;
	logic [1:0]  rl;
	logic [1:0]  ams;
	logic [2:0]  pms;
	logic [3:0]  keyon;

	// reference model
	fm_ch_param_t exp_ch [`FM_NUM_CH];
	logic [2:0]   pend_blk [`FM_NUM_CH];
	logic [2:0]   pend_hi [`FM_NUM_CH];
	logic         exp_lfo_en;
	logic [2:0]   exp_lfo_freq;
	int           exp_div;
	logic         glob_ok; // model and globals agree
	int           seed;
	int           r;

	fm_regif_top fm_regif_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		$display("RESULT: FAIL");
		$fatal(1, "stopped on first mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic expect_val(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// global registers track the model once a write has settled
	assert property (@(posedge clk) disable iff (rst || !glob_ok) lfo_en == exp_lfo_en)
		else report_mismatch("lfo_en", $sampled(exp_lfo_en), $sampled(lfo_en));
	assert property (@(posedge clk) disable iff (rst || !glob_ok) lfo_freq == exp_lfo_freq)
		else report_mismatch("lfo_freq", $sampled(exp_lfo_freq), $sampled(lfo_freq));

	// a bound assertion failure ends the run at once
	always @(fm_regif_top_i.fm_regif_sva_i.fail_cnt)
		if (fm_regif_top_i.fm_regif_sva_i.fail_cnt != 0)
			abort_run("bound timing assertion failed");

	// write pulse held 2 clocks high and 2 low
	task automatic bus_write(input logic a, input logic [7:0] d);
		@(posedge clk);
		#2;
		addr  = a;
		din   = d;
		write = 1'b1;
		repeat (2) @(posedge clk);
		#2 write = 1'b0;
		@(posedge clk);
	endtask

	function automatic void apply_write(input logic [7:0] ra, input logic [7:0] d);
		int ch;
		ch = ra[1:0];
		case (ra)
			REG_LFO: begin
				exp_lfo_en   = d[3];
				exp_lfo_freq = d[2:0];
			end
			REG_DIV6: exp_div = 6;
			REG_DIV3: exp_div = 3;
			REG_DIV2: exp_div = 2;
			REG_KON: begin
				if (d[1:0] < `FM_NUM_CH)
					exp_ch[d[1:0]].keyon = d[7:4];
			end
			default: begin
				if (ch < `FM_NUM_CH && ra[7:4] == 4'hA && ra[3:2] == 2'd0) begin
					exp_ch[ch].fnum  = {pend_hi[ch], d}; // pending high part commits here
					exp_ch[ch].block = pend_blk[ch];
				end else if (ch < `FM_NUM_CH && ra[7:4] == 4'hA && ra[3:2] == 2'd1) begin
					pend_blk[ch] = d[5:3];
					pend_hi[ch]  = d[2:0];
				end else if (ch < `FM_NUM_CH && ra[7:4] == 4'hB && ra[3:2] == 2'd0) begin
					exp_ch[ch].fb  = d[5:3];
					exp_ch[ch].alg = d[2:0];
				end else if (ch < `FM_NUM_CH && ra[7:4] == 4'hB && ra[3:2] == 2'd1) begin
					exp_ch[ch].rl  = d[7:6];
					exp_ch[ch].ams = d[5:4];
					exp_ch[ch].pms = d[2:0];
				end
			end
		endcase
	endfunction

	task automatic write_reg(input logic [7:0] ra, input logic [7:0] d);
		glob_ok = 1'b0;
		bus_write(1'b0, ra);
		apply_write(ra, d);
		bus_write(1'b1, d);
		#2 glob_ok = 1'b1;
	endtask

	// outputs settle two clocks after the slot before ch ticks
	task automatic check_scan(input int ch);
		logic [1:0] prev;
		int         n;
		prev = (ch == 0) ? 2'(`FM_NUM_CH - 1) : 2'(ch - 1);
		n = 0;
		@(negedge clk);
		while (!(clk_en && slot_ch == prev)) begin
			n++;
			if (n > 60)
				abort_run($sformatf("scanner never reached channel %0d", ch));
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		expect_val("slot_ch", ch, slot_ch);
		expect_val("fnum", exp_ch[ch].fnum, fnum);
		expect_val("block", exp_ch[ch].block, block);
		expect_val("fb", exp_ch[ch].fb, fb);
		expect_val("alg", exp_ch[ch].alg, alg);
		expect_val("rl", exp_ch[ch].rl, rl);
		expect_val("ams", exp_ch[ch].ams, ams);
		expect_val("pms", exp_ch[ch].pms, pms);
		expect_val("keyon", exp_ch[ch].keyon, keyon);
	endtask

	task automatic wait_busy_low();
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			n++;
			if (n > 100)
				abort_run("busy stuck high");
			@(negedge clk);
		end
	endtask

	// count clk_en ticks from the control write until the flag shows
	task automatic run_timer(input logic [7:0] ctrl, input bit use_b, input int exp_ticks);
		int n;
		int ticks;
		bus_write(1'b0, REG_TIMER);
		fork
			bus_write(1'b1, ctrl);
			begin
				repeat (2) @(posedge clk); // second edge is the data write
				n = 0;
				ticks = 0;
				@(negedge clk);
				while (!(use_b ? flag_b : flag_a)) begin
					if (clk_en)
						ticks++;
					n++;
					if (n > 5000)
						abort_run("timer flag never set");
					@(negedge clk);
				end
			end
		join
		expect_val(use_b ? "flag_b ticks" : "flag_a ticks", exp_ticks, ticks);
		expect_val("irq_n", 0, irq_n);
	endtask

	task automatic check_divider(input logic [7:0] ra);
		int n;
		int gap;
		write_reg(ra, 8'h00);
		n = 0;
		@(negedge clk);
		while (!clk_en) begin
			n++;
			if (n > 50)
				abort_run("clk_en stopped pulsing");
			@(negedge clk);
		end
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
			if (gap > 50)
				abort_run("no second clk_en pulse");
		end while (!clk_en);
		expect_val("clk_en spacing", exp_div, gap);
	endtask

	initial begin
		seed    = 58317;
		rst     = 1'b1;
		cen     = 1'b1;
		din     = 8'h00;
		write   = 1'b0;
		addr    = 1'b0;
		glob_ok = 1'b0;
		exp_lfo_en   = 1'b0;
		exp_lfo_freq = 3'd0;
		exp_div      = 6;
		for (int i = 0; i < `FM_NUM_CH; i++) begin
			exp_ch[i]   = '0;
			pend_blk[i] = 3'd0;
			pend_hi[i]  = 3'd0;
		end
		repeat (5) @(posedge clk);
		#2 rst = 1'b0;
		glob_ok = 1'b1;

		// block high alone leaves the frequency alone
		for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
			r = $random(seed);
			write_reg(8'(8'hB0 + ch), r[7:0]);
			write_reg(8'(8'hB4 + ch), r[15:8]);
			write_reg(8'(8'hA4 + ch), r[23:16]);
			check_scan(ch);
			write_reg(8'(8'hA0 + ch), r[31:24]);
			check_scan(ch);
		end

		// key-on masks where channel 3 goes nowhere
		for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
			r = $random(seed);
			write_reg(REG_KON, {r[3:0], 2'b00, 2'(ch)});
		end
		write_reg(REG_KON, 8'hF3);
		for (int ch = 0; ch < `FM_NUM_CH; ch++)
			check_scan(ch);

		// lfo write with busy only on data writes
		wait_busy_low();
		glob_ok = 1'b0;
		bus_write(1'b0, REG_LFO);
		@(negedge clk);
		expect_val("busy", 0, busy);
		apply_write(REG_LFO, 8'h0D);
		bus_write(1'b1, 8'h0D);
		@(negedge clk);
		expect_val("busy", 1, busy);
		glob_ok = 1'b1;

		// timer A then timer B
		write_reg(REG_CLKA1, 8'(VAL_A >> 2));
		write_reg(REG_CLKA2, 8'(VAL_A & 3));
		run_timer(8'h05, 1'b0, 1024 - VAL_A);
		write_reg(REG_TIMER, 8'h10);
		@(negedge clk);
		expect_val("flag_a", 0, flag_a);
		expect_val("irq_n", 1, irq_n);
		write_reg(REG_CLKB, 8'(VAL_B));
		run_timer(8'h0A, 1'b1, `FM_TB_PRESCALE * (256 - VAL_B));
		write_reg(REG_TIMER, 8'h20);
		@(negedge clk);
		expect_val("flag_b", 0, flag_b);
		expect_val("irq_n", 1, irq_n);

		check_divider(REG_DIV3);
		check_divider(REG_DIV2);
		check_divider(REG_DIV6);
		for (int ch = 0; ch < `FM_NUM_CH; ch++)
			check_scan(ch);

		repeat (4) @(posedge clk);
		if (fm_regif_top_i.fm_regif_sva_i.fail_cnt == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("bound assertion failures: %0d", fm_regif_top_i.fm_regif_sva_i.fail_cnt);
			$display("RESULT: FAIL");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule
